/* hw/ahb_mst_pkg.sv */
// master port package: bus widths, HTRANS and HRESP codes, request and response structs
package ahb_mst_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    localparam int NUM_MASTERS = 3;
    // wide enough to index every master
    localparam int MST_IDX_W   = 2;
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;

    //////////////////////////////
    // bus codes
    //////////////////////////////

    // transfer types
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // AHB-Lite response
    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    //////////////////////////////
    // types
    //////////////////////////////

    // address and control of one master, 45 bits
    typedef struct packed {
        logic [1:0]        htrans;
        logic [2:0]        hburst;
        logic [2:0]        hsize;
        logic              hwrite;
        logic [3:0]        hprot;
        logic [ADDR_W-1:0] haddr;
    } ahb_req_t;

    // response to a master, 34 bits
    typedef struct packed {
        logic [DATA_W-1:0] hrdata;
        logic              hready;
        logic              hresp;
    } ahb_rsp_t;

    // one flag per master, used for hsel and grant
    typedef logic [NUM_MASTERS-1:0] mst_vec_t;

endpackage

/* hw/ahb_mst_arbiter.sv */
// round-robin arbiter with registered one-hot grant and last-granted pointer
`timescale 1ns/100ps

module ahb_mst_arbiter
    import ahb_mst_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    // requests, one hsel bit per master
    input  mst_vec_t hsel_i,
    input  logic     slv_hready_i,
    // one-hot or zero
    output mst_vec_t grant_o
);

    //////////////////////////////
    // declarations
    //////////////////////////////

    mst_vec_t             grant_q;
    mst_vec_t             grant_d;
    logic [MST_IDX_W-1:0] last_q;
    logic [MST_IDX_W-1:0] winner_idx;
    logic                 winner_vld;
    logic                 rearb;
    logic                 holder_req;

    //////////////////////////////
    // winner selection
    //////////////////////////////

    // first requester after the last-granted master, counting up and wrapping
    always_comb begin
        int cand;
        winner_idx = '0;
        winner_vld = 1'b0;
        for (int ofs = 1; ofs <= NUM_MASTERS; ofs++) begin
            cand = (int'(last_q) + ofs) % NUM_MASTERS;
            if (!winner_vld && hsel_i[cand]) begin
                winner_vld = 1'b1;
                winner_idx = MST_IDX_W'(cand);
            end
        end
    end

    // current holder still asking for the bus
    assign holder_req = |(grant_q & hsel_i);

    // free bus, or the holder let go at an edge that completes the address phase
    assign rearb = ~(|grant_q) | (slv_hready_i & ~holder_req);

    always_comb begin
        grant_d = grant_q;
        if (rearb) begin
            if (winner_vld) begin
                grant_d = mst_vec_t'(1) << winner_idx;
            end else begin
                grant_d = '0;
            end
        end
    end

    //////////////////////////////
    // state
    //////////////////////////////

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            grant_q <= '0;
        end else begin
            grant_q <= grant_d;
        end
    end

    // starts at the top index so master 0 is served first
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            last_q <= MST_IDX_W'(NUM_MASTERS - 1);
        end else if (rearb && winner_vld) begin
            last_q <= winner_idx;
        end
    end

    assign grant_o = grant_q;

endmodule

/* hw/ahb_mst_mux.sv */
// address-phase mux, data-phase owner register, write-data mux and response routing
`timescale 1ns/100ps

module ahb_mst_mux
    import ahb_mst_pkg::*;
(
    input  logic                               HCLK,
    input  logic                               HRESETn,
    input  mst_vec_t                           grant_i,
    input  mst_vec_t                           mst_hsel_i,
    input  ahb_req_t [NUM_MASTERS-1:0]         mst_req_i,
    input  logic [NUM_MASTERS-1:0][DATA_W-1:0] mst_hwdata_i,
    input  ahb_rsp_t                           slv_rsp_i,
    output ahb_req_t                           slv_req_o,
    output logic [DATA_W-1:0]                  slv_hwdata_o,
    output ahb_rsp_t [NUM_MASTERS-1:0]         mst_rsp_o
);

    //////////////////////////////
    // declarations
    //////////////////////////////

    logic [MST_IDX_W-1:0] grant_idx;
    logic                 addr_active;
    logic [MST_IDX_W-1:0] owner_idx_q;
    logic                 owner_vld_q;

    //////////////////////////////
    // address phase
    //////////////////////////////

    // granted master straight to the slave, IDLE with zero fields otherwise
    always_comb begin
        slv_req_o        = '0;
        slv_req_o.htrans = HTRANS_IDLE;
        grant_idx        = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (grant_i[i]) begin
                slv_req_o = mst_req_i[i];
                grant_idx = MST_IDX_W'(i);
            end
        end
    end

    // only NONSEQ and SEQ open a data phase
    assign addr_active = (slv_req_o.htrans == HTRANS_NONSEQ) ||
                         (slv_req_o.htrans == HTRANS_SEQ);

    //////////////////////////////
    // data-phase owner
    //////////////////////////////

    // moves on only when the slave completes the current data phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            owner_vld_q <= 1'b0;
            owner_idx_q <= '0;
        end else if (slv_rsp_i.hready) begin
            owner_vld_q <= addr_active;
            owner_idx_q <= grant_idx;
        end
    end

    // write data belongs to the data phase, not to the current grant
    assign slv_hwdata_o = owner_vld_q ? mst_hwdata_i[owner_idx_q] : '0;

    //////////////////////////////
    // responses
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (owner_vld_q && (owner_idx_q == MST_IDX_W'(i))) begin
                mst_rsp_o[i] = slv_rsp_i;
            end else if (mst_hsel_i[i] && !grant_i[i]) begin
                // requester without the bus is stalled
                mst_rsp_o[i].hrdata = '0;
                mst_rsp_o[i].hready = 1'b0;
                mst_rsp_o[i].hresp  = HRESP_OKAY;
            end else begin
                // idle or address-only master tracks the bus ready
                mst_rsp_o[i].hrdata = '0;
                mst_rsp_o[i].hready = slv_rsp_i.hready;
                mst_rsp_o[i].hresp  = HRESP_OKAY;
            end
        end
    end

endmodule

/* hw/ahb_mst_port.sv */
// AHB-Lite interconnect master port: arbiter and address/data mux for one slave
`timescale 1ns/100ps

module ahb_mst_port
    import ahb_mst_pkg::*;
(
    input  logic                               HCLK,
    input  logic                               HRESETn,

    //////////////////////////////
    // master side
    //////////////////////////////

    input  mst_vec_t                           mst_hsel_i,
    input  ahb_req_t [NUM_MASTERS-1:0]         mst_req_i,
    input  logic [NUM_MASTERS-1:0][DATA_W-1:0] mst_hwdata_i,
    output ahb_rsp_t [NUM_MASTERS-1:0]         mst_rsp_o,
    // registered grant, also seen by the masters
    output mst_vec_t                           mst_grant_o,

    //////////////////////////////
    // slave side
    //////////////////////////////

    input  ahb_rsp_t                           slv_rsp_i,
    output ahb_req_t                           slv_req_o,
    output logic [DATA_W-1:0]                  slv_hwdata_o
);

    // hsel doubles as the arbitration request
    ahb_mst_arbiter ahb_mst_arbiter_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .hsel_i       (mst_hsel_i),
        .slv_hready_i (slv_rsp_i.hready),
        .grant_o      (mst_grant_o)
    );

    // address mux follows the grant, data path follows the owner
    ahb_mst_mux ahb_mst_mux_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .grant_i      (mst_grant_o),
        .mst_hsel_i   (mst_hsel_i),
        .mst_req_i    (mst_req_i),
        .mst_hwdata_i (mst_hwdata_i),
        .slv_rsp_i    (slv_rsp_i),
        .slv_req_o    (slv_req_o),
        .slv_hwdata_o (slv_hwdata_o),
        .mst_rsp_o    (mst_rsp_o)
    );

endmodule

/* dv/ahb_mst_port_assert.sv */
// concurrent assertions on grant and slave request, bound into the master port
`timescale 1ns/100ps

module ahb_mst_port_assert
    import ahb_mst_pkg::*;
(
    input logic     HCLK,
    input logic     HRESETn,
    input mst_vec_t grant_i,
    input logic     slv_hready_i,
    input ahb_req_t slv_req_i
);

    // at most one owner of the address phase
    grant_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(grant_i))
        else $error("grant %b is not one-hot or zero", grant_i);

    // wait states freeze arbitration
    grant_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !slv_hready_i |=> $stable(grant_i))
        else $error("grant changed while slave hready was low");

    idle_no_grant: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (grant_i == '0) |-> (slv_req_i.htrans == HTRANS_IDLE))
        else $error("slave htrans not IDLE without a grant");

endmodule

bind ahb_mst_port ahb_mst_port_assert ahb_mst_port_assert_inst (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .grant_i      (mst_grant_o),
    .slv_hready_i (slv_rsp_i.hready),
    .slv_req_i    (slv_req_o)
);

/* dv/tb_ahb_mst_port.sv */
// testbench top: clock, reset, DUT instance, slave model, directed tests, timeout, final report
`timescale 1ns/100ps

module tb_ahb_mst_port
    import ahb_mst_pkg::*;
();

    logic                               HCLK;
    logic                               HRESETn;
    mst_vec_t                           mst_hsel;
    ahb_req_t [NUM_MASTERS-1:0]         mst_req;
    logic [NUM_MASTERS-1:0][DATA_W-1:0] mst_hwdata;
    ahb_rsp_t [NUM_MASTERS-1:0]         mst_rsp;
    mst_vec_t                           mst_grant;
    ahb_rsp_t                           slv_rsp;
    ahb_req_t                           slv_req;
    logic [DATA_W-1:0]                  slv_hwdata;

    integer seed = 60794;
    int     err_cnt = 0;
    int     cycle_cnt = 0;
    // five tests of at most 60 cycles each, plus margin
    int     cycle_limit = 400;
    int     grant_wait_max = 20;

    ahb_mst_port ahb_mst_port_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .mst_hsel_i   (mst_hsel),
        .mst_req_i    (mst_req),
        .mst_hwdata_i (mst_hwdata),
        .mst_rsp_o    (mst_rsp),
        .mst_grant_o  (mst_grant),
        .slv_rsp_i    (slv_rsp),
        .slv_req_o    (slv_req),
        .slv_hwdata_o (slv_hwdata)
    );

    initial begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    always @(posedge HCLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the tests did not complete within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task report_mismatch(input string msg);
        err_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // slave model, called on a rising edge
    task drive_slave(input logic rdy, input logic resp, input logic [DATA_W-1:0] rdata);
        slv_rsp.hready <= rdy;
        slv_rsp.hresp  <= resp;
        slv_rsp.hrdata <= rdata;
    endtask

    // single word transfer, word aligned
    function automatic ahb_req_t make_req(input logic [1:0] trans, input logic write,
                                          input logic [ADDR_W-1:0] addr);
        ahb_req_t req;
        req.htrans = trans;
        req.hburst = 3'b000;
        req.hsize  = 3'b010;
        req.hwrite = write;
        req.hprot  = 4'b0011;
        req.haddr  = {addr[ADDR_W-1:2], 2'b00};
        return req;
    endfunction

    task apply_reset();
        @(posedge HCLK);
        HRESETn    <= 1'b0;
        mst_hsel   <= '0;
        mst_req    <= '0;
        mst_hwdata <= '0;
        drive_slave(1'b1, HRESP_OKAY, '0);
        repeat (3) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(negedge HCLK);
    endtask

    // returns at a falling edge once grant differs from prev
    task wait_grant_change(input mst_vec_t prev, output int cycles);
        cycles = 0;
        do begin
            @(posedge HCLK);
            @(negedge HCLK);
            cycles++;
        end while ((mst_grant === prev) && (cycles < grant_wait_max));
        if (mst_grant === prev) begin
            err_cnt++;
            $display("grant stayed at %b for %0d cycles, no arbitration happened",
                     prev, grant_wait_max);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task test_reset_state();
        apply_reset();
        if (mst_grant !== '0) report_mismatch("grant not zero after reset");
        if (slv_req.htrans !== HTRANS_IDLE) report_mismatch("slave htrans not IDLE after reset");
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (mst_rsp[i].hready !== 1'b1 || mst_rsp[i].hresp !== HRESP_OKAY ||
                mst_rsp[i].hrdata !== '0) begin
                report_mismatch($sformatf("master %0d response not idle after reset", i));
            end
        end
    endtask

    task test_single_write();
        ahb_req_t          req;
        logic [DATA_W-1:0] wdata;
        int                cycles;
        apply_reset();
        req   = make_req(HTRANS_NONSEQ, 1'b1, $random(seed));
        wdata = $random(seed);
        @(posedge HCLK);
        mst_hsel[1] <= 1'b1;
        mst_req[1]  <= req;
        wait_grant_change('0, cycles);
        if (cycles != 1) report_mismatch($sformatf("grant after %0d cycles, expected 1", cycles));
        if (mst_grant !== 3'b010) report_mismatch($sformatf("grant %b, expected 010", mst_grant));
        if (slv_req !== req) report_mismatch("slave request differs from master 1 request");
        // address accepted here, data phase follows
        @(posedge HCLK);
        mst_hsel[1]   <= 1'b0;
        mst_req[1]    <= '0;
        mst_hwdata[1] <= wdata;
        @(negedge HCLK);
        if (slv_hwdata !== wdata) begin
            report_mismatch($sformatf("slave hwdata %h, expected %h", slv_hwdata, wdata));
        end
    endtask

    task test_round_robin();
        int       exp_order [4];
        mst_vec_t prev;
        int       cur;
        int       last;
        int       cycles;
        exp_order = '{0, 1, 2, 0};
        apply_reset();
        @(posedge HCLK);
        for (int i = 0; i < NUM_MASTERS; i++) begin
            mst_hsel[i] <= 1'b1;
            mst_req[i]  <= make_req(HTRANS_NONSEQ, 1'b0, $random(seed));
        end
        prev = '0;
        last = -1;
        for (int k = 0; k < 4; k++) begin
            wait_grant_change(prev, cycles);
            prev = mst_grant;
            cur  = 0;
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (mst_grant[i]) cur = i;
            end
            if (mst_grant !== (mst_vec_t'(1) << exp_order[k])) begin
                report_mismatch($sformatf("grant %0d is %b, expected master %0d",
                                          k, mst_grant, exp_order[k]));
            end
            // holder's transfer accepted, it leaves and the one before asks again
            @(posedge HCLK);
            mst_hsel[cur] <= 1'b0;
            mst_req[cur]  <= '0;
            if (last >= 0) begin
                mst_hsel[last] <= 1'b1;
                mst_req[last]  <= make_req(HTRANS_NONSEQ, 1'b0, $random(seed));
            end
            last = cur;
        end
    endtask

    task test_back_pressure();
        ahb_req_t wr_req;
        int       stall;
        int       cycles;
        apply_reset();
        stall  = 1 + ($unsigned($random(seed)) % 5);
        wr_req = make_req(HTRANS_NONSEQ, 1'b1, $random(seed));
        @(posedge HCLK);
        mst_hsel   <= 3'b101;
        mst_req[0] <= wr_req;
        mst_req[2] <= make_req(HTRANS_NONSEQ, 1'b0, $random(seed));
        wait_grant_change('0, cycles);
        if (mst_grant !== 3'b001) report_mismatch("master 0 not granted first");
        if (slv_req !== wr_req) report_mismatch("slave request differs from master 0 request");
        // first write accepted, the slave then stalls
        @(posedge HCLK);
        mst_hwdata[0] <= $random(seed);
        drive_slave(1'b0, HRESP_OKAY, '0);
        repeat (stall) begin
            @(negedge HCLK);
            if (mst_grant !== 3'b001) report_mismatch("grant moved during wait states");
            if (slv_req !== wr_req) report_mismatch("slave request moved during wait states");
            if (mst_rsp[0].hready !== 1'b0) report_mismatch("owner saw hready high in a stall");
            if (mst_rsp[2].hready !== 1'b0) report_mismatch("waiting master 2 saw hready high");
            if (mst_rsp[1].hready !== 1'b0) report_mismatch("idle master 1 not tracking hready");
        end
        @(posedge HCLK);
        drive_slave(1'b1, HRESP_OKAY, '0);
        mst_hsel <= '0;
        mst_req  <= '0;
    endtask

    task check_error_response(input logic [DATA_W-1:0] rdata, input logic rdy);
        if (mst_rsp[2].hrdata !== rdata) report_mismatch("master 2 hrdata differs from slave");
        if (mst_rsp[2].hresp !== HRESP_ERROR) report_mismatch("master 2 missed the ERROR");
        if (mst_rsp[2].hready !== rdy) report_mismatch("master 2 hready differs from slave");
        for (int i = 0; i < 2; i++) begin
            if (mst_rsp[i].hrdata !== '0 || mst_rsp[i].hresp !== HRESP_OKAY ||
                mst_rsp[i].hready !== rdy) begin
                report_mismatch($sformatf("master %0d sees the read response of master 2", i));
            end
        end
    endtask

    task test_read_error();
        logic [DATA_W-1:0] rdata;
        int                cycles;
        apply_reset();
        rdata = $random(seed);
        @(posedge HCLK);
        mst_hsel[2] <= 1'b1;
        mst_req[2]  <= make_req(HTRANS_NONSEQ, 1'b0, $random(seed));
        wait_grant_change('0, cycles);
        if (mst_grant !== 3'b100) report_mismatch($sformatf("grant %b, expected 100", mst_grant));
        // two-cycle ERROR response on the read data phase
        @(posedge HCLK);
        mst_hsel[2] <= 1'b0;
        mst_req[2]  <= '0;
        drive_slave(1'b0, HRESP_ERROR, rdata);
        @(negedge HCLK);
        check_error_response(rdata, 1'b0);
        @(posedge HCLK);
        drive_slave(1'b1, HRESP_ERROR, rdata);
        @(negedge HCLK);
        check_error_response(rdata, 1'b1);
        @(posedge HCLK);
        drive_slave(1'b1, HRESP_OKAY, '0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        HRESETn    <= 1'b0;
        mst_hsel   <= '0;
        mst_req    <= '0;
        mst_hwdata <= '0;
        slv_rsp    <= '0;
        test_reset_state();
        test_single_write();
        test_round_robin();
        test_back_pressure();
        test_read_error();
        repeat (2) @(posedge HCLK);
        $display("tests done, errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src.f */
hw/ahb_mst_pkg.sv
hw/ahb_mst_arbiter.sv
hw/ahb_mst_mux.sv
hw/ahb_mst_port.sv
dv/ahb_mst_port_assert.sv
dv/tb_ahb_mst_port.sv

/* Bender.yml */
package:
  name: ahb_mst_port

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - hw/ahb_mst_pkg.sv
      - hw/ahb_mst_arbiter.sv
      - hw/ahb_mst_mux.sv
      - hw/ahb_mst_port.sv

  # testbench and bound assertions
  - target: test
    files:
      - dv/ahb_mst_port_assert.sv
      - dv/tb_ahb_mst_port.sv
